/* all.f */
+incdir+hw
hw/commit_pkg.sv
hw/commit_ctrl.sv
hw/excp_csr.sv
hw/commit_top.sv
testbench/commit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the commit stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ns -j 0 \
    -f all.f --top-module commit_tb -o commit_sim
./obj_dir/commit_sim

/* testbench/commit_tb.sv */
`timescale 1ns/1ns
`include "commit_settings.svh"

module commit_tb;
    import commit_pkg::*;

    // six tests at roughly 60 cycles each plus reset and margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                 clk;
    logic                 rst;
    logic                 s0_valid_i;
    op_e                  s0_op_i;
    logic [`ADDR_W-1:0]   s0_pc_i;
    logic [`EXCP_W-1:0]   s0_excp_i;
    logic [`ADDR_W-1:0]   s0_mem_addr_i;
    logic                 s0_wb_we_i;
    logic [`RF_AW-1:0]    s0_wb_addr_i;
    logic [`DATA_W-1:0]   s0_wb_data_i;
    logic                 s1_valid_i;
    op_e                  s1_op_i;
    logic [`ADDR_W-1:0]   s1_pc_i;
    logic [`EXCP_W-1:0]   s1_excp_i;
    logic [`ADDR_W-1:0]   s1_mem_addr_i;
    logic                 s1_wb_we_i;
    logic [`RF_AW-1:0]    s1_wb_addr_i;
    logic [`DATA_W-1:0]   s1_wb_data_i;
    logic [1:0]           ex_ready_i;
    logic [1:0]           mem1_ready_i;
    logic [1:0]           mem2_ready_i;
    logic                 rf0_we_o;
    logic [`RF_AW-1:0]    rf0_addr_o;
    logic [`DATA_W-1:0]   rf0_data_o;
    logic                 rf1_we_o;
    logic [`RF_AW-1:0]    rf1_addr_o;
    logic [`DATA_W-1:0]   rf1_data_o;
    logic [1:0]           commit_mask_o;
    logic                 redirect_valid_o;
    logic [`ADDR_W-1:0]   redirect_pc_o;
    logic [`STAGES-1:0]   flush_o;
    logic [`STAGES-1:0]   advance_o;
    logic [`STAGES-1:0]   clear_o;
    logic [`ADDR_W-1:0]   s_axil_awaddr_i;
    logic                 s_axil_awvalid_i;
    logic                 s_axil_awready_o;
    logic [`DATA_W-1:0]   s_axil_wdata_i;
    logic [`DATA_W/8-1:0] s_axil_wstrb_i;
    logic                 s_axil_wvalid_i;
    logic                 s_axil_wready_o;
    logic [1:0]           s_axil_bresp_o;
    logic                 s_axil_bvalid_o;
    logic                 s_axil_bready_i;
    logic [`ADDR_W-1:0]   s_axil_araddr_i;
    logic                 s_axil_arvalid_i;
    logic                 s_axil_arready_o;
    logic [`DATA_W-1:0]   s_axil_rdata_o;
    logic [1:0]           s_axil_rresp_o;
    logic                 s_axil_rvalid_o;
    logic                 s_axil_rready_i;

    int                   cycle_count;
    logic [31:0]          lcg_state;
    // values driven on the slots by the latest drive_slots call
    logic [31:0]          pc0;
    logic [31:0]          pc1;
    logic [31:0]          ma0;
    logic [31:0]          ma1;
    logic [31:0]          d0;
    logic [31:0]          d1;
    logic [31:0]          eentry_val;
    logic [31:0]          tlbrentry_val;

    commit_top uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout, the tests did not complete within the cycle limit");
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ESTAT word with esubcode in 30:22 and ecode in 21:16
    function automatic logic [31:0] estat_word(input logic [5:0] ecode, input logic [8:0] esub);
        return {1'b0, esub, ecode, 16'h0000};
    endfunction

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic aw_done;
        logic w_done;
        logic aw_hs;
        logic w_hs;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clk);
        s_axil_awaddr_i  <= addr;
        s_axil_awvalid_i <= 1'b1;
        s_axil_wdata_i   <= data;
        s_axil_wstrb_i   <= strb;
        s_axil_wvalid_i  <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            aw_hs = s_axil_awvalid_i & s_axil_awready_o;
            w_hs  = s_axil_wvalid_i & s_axil_wready_o;
            @(posedge clk);
            if (aw_hs) begin
                s_axil_awvalid_i <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                s_axil_wvalid_i <= 1'b0;
                w_done = 1'b1;
            end
        end
        s_axil_bready_i <= 1'b1;
        @(negedge clk);
        while (!s_axil_bvalid_o) begin
            @(negedge clk);
        end
        check_eq("axil bresp", 32'd0, 32'(s_axil_bresp_o));
        @(posedge clk);
        s_axil_bready_i <= 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        logic ar_hs;
        ar_hs = 1'b0;
        @(posedge clk);
        s_axil_araddr_i  <= addr;
        s_axil_arvalid_i <= 1'b1;
        while (!ar_hs) begin
            @(negedge clk);
            ar_hs = s_axil_arready_o;
            @(posedge clk);
        end
        s_axil_arvalid_i <= 1'b0;
        s_axil_rready_i  <= 1'b1;
        @(negedge clk);
        while (!s_axil_rvalid_o) begin
            @(negedge clk);
        end
        data = s_axil_rdata_o;
        check_eq("axil rresp", 32'd0, 32'(s_axil_rresp_o));
        @(posedge clk);
        s_axil_rready_i <= 1'b0;
    endtask

    task automatic read_check(input string name, input logic [31:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        axil_read(addr, rd);
        check_eq(name, exp, rd);
    endtask

    // slot 0 always valid and outputs sampled at the following negedge
    task automatic drive_slots(input op_e op0, input logic [15:0] ex0, input logic v1,
                               input op_e op1, input logic [15:0] ex1);
        @(posedge clk);
        pc0 = lcg_next() & 32'hffff_fffc;
        pc1 = pc0 + 32'd4;
        ma0 = lcg_next();
        ma1 = lcg_next();
        d0  = lcg_next();
        d1  = lcg_next();
        s0_valid_i    <= 1'b1;
        s0_op_i       <= op0;
        s0_pc_i       <= pc0;
        s0_excp_i     <= ex0;
        s0_mem_addr_i <= ma0;
        s0_wb_we_i    <= 1'b1;
        s0_wb_addr_i  <= 5'd3;
        s0_wb_data_i  <= d0;
        s1_valid_i    <= v1;
        s1_op_i       <= op1;
        s1_pc_i       <= pc1;
        s1_excp_i     <= ex1;
        s1_mem_addr_i <= ma1;
        s1_wb_we_i    <= 1'b1;
        s1_wb_addr_i  <= 5'd7;
        s1_wb_data_i  <= d1;
        @(negedge clk);
    endtask

    // the edge that drops the slots is the one that updates the CSRs
    task automatic clear_slots();
        @(posedge clk);
        s0_valid_i <= 1'b0;
        s1_valid_i <= 1'b0;
        s0_excp_i  <= '0;
        s1_excp_i  <= '0;
        s0_op_i    <= OP_NORMAL;
        s1_op_i    <= OP_NORMAL;
    endtask

    task automatic test_csr_access();
        logic [31:0] era_val;
        read_check("reset eentry", `CSR_EENTRY, 32'd0);
        read_check("reset tlbrentry", `CSR_TLBRENTRY, 32'd0);
        read_check("reset era", `CSR_ERA, 32'd0);
        read_check("reset estat", `CSR_ESTAT, 32'd0);
        read_check("reset badv", `CSR_BADV, 32'd0);
        eentry_val    = 32'h1c00_8000;
        tlbrentry_val = 32'h1c00_f000;
        era_val       = lcg_next();
        axil_write(`CSR_EENTRY, eentry_val, 4'hf);
        axil_write(`CSR_TLBRENTRY, tlbrentry_val, 4'hf);
        axil_write(`CSR_ERA, era_val, 4'hf);
        axil_write(`CSR_ESTAT, 32'hffff_ffff, 4'hf);
        axil_write(`CSR_BADV, 32'h1234_5678, 4'hf);
        read_check("csr eentry", `CSR_EENTRY, eentry_val);
        read_check("csr tlbrentry", `CSR_TLBRENTRY, tlbrentry_val);
        read_check("csr era", `CSR_ERA, era_val);
        read_check("csr estat ro", `CSR_ESTAT, 32'd0);
        read_check("csr badv ro", `CSR_BADV, 32'd0);
        // partial strobes only touch the selected bytes
        axil_write(`CSR_ERA, 32'haabb_ccdd, 4'b0101);
        read_check("csr era strobe", `CSR_ERA,
                   {era_val[31:24], 8'hbb, era_val[15:8], 8'hdd});
    endtask

    task automatic test_dual_commit();
        drive_slots(OP_NORMAL, 16'h0000, 1'b1, OP_NORMAL, 16'h0000);
        check_eq("dual mask", 32'b11, 32'(commit_mask_o));
        check_eq("dual rf0 we", 32'd1, 32'(rf0_we_o));
        check_eq("dual rf0 addr", 32'd3, 32'(rf0_addr_o));
        check_eq("dual rf0 data", d0, rf0_data_o);
        check_eq("dual rf1 we", 32'd1, 32'(rf1_we_o));
        check_eq("dual rf1 addr", 32'd7, 32'(rf1_addr_o));
        check_eq("dual rf1 data", d1, rf1_data_o);
        check_eq("dual redirect", 32'd0, 32'(redirect_valid_o));
        // syscall op without a cause bit still blocks slot 1
        drive_slots(OP_SYSCALL, 16'h0000, 1'b1, OP_NORMAL, 16'h0000);
        check_eq("syscall mask", 32'b01, 32'(commit_mask_o));
        check_eq("syscall rf0 we", 32'd1, 32'(rf0_we_o));
        check_eq("syscall rf1 we", 32'd0, 32'(rf1_we_o));
        clear_slots();
    endtask

    task automatic test_excp_priority();
        // PIF and ALE in slot 0 against SYS in slot 1
        drive_slots(OP_NORMAL, 16'h0208, 1'b1, OP_NORMAL, 16'h0020);
        check_eq("prio redirect", 32'd1, 32'(redirect_valid_o));
        check_eq("prio target", eentry_val, redirect_pc_o);
        check_eq("prio flush", 32'h7f, 32'(flush_o));
        check_eq("prio rf0 we", 32'd0, 32'(rf0_we_o));
        check_eq("prio rf1 we", 32'd0, 32'(rf1_we_o));
        check_eq("prio mask", 32'd0, 32'(commit_mask_o));
        clear_slots();
        read_check("prio estat", `CSR_ESTAT, estat_word(6'h03, 9'd0));
        read_check("prio badv", `CSR_BADV, pc0);
        read_check("prio era", `CSR_ERA, pc0);
        // only slot 1 faults with ADEM
        drive_slots(OP_NORMAL, 16'h0000, 1'b1, OP_NORMAL, 16'h0400);
        check_eq("adem mask", 32'b01, 32'(commit_mask_o));
        check_eq("adem rf0 we", 32'd1, 32'(rf0_we_o));
        check_eq("adem rf0 data", d0, rf0_data_o);
        check_eq("adem rf1 we", 32'd0, 32'(rf1_we_o));
        check_eq("adem target", eentry_val, redirect_pc_o);
        clear_slots();
        read_check("adem estat", `CSR_ESTAT, estat_word(6'h08, 9'd1));
        read_check("adem badv", `CSR_BADV, ma1);
        read_check("adem era", `CSR_ERA, pc1);
    endtask

    task automatic test_tlbr_ertn();
        logic [31:0] era_rd;
        drive_slots(OP_NORMAL, 16'h0800, 1'b0, OP_NORMAL, 16'h0000);
        check_eq("tlbr redirect", 32'd1, 32'(redirect_valid_o));
        check_eq("tlbr target", tlbrentry_val, redirect_pc_o);
        clear_slots();
        read_check("tlbr estat", `CSR_ESTAT, estat_word(6'h3f, 9'd0));
        read_check("tlbr badv", `CSR_BADV, ma0);
        axil_read(`CSR_ERA, era_rd);
        check_eq("tlbr era", pc0, era_rd);
        drive_slots(OP_ERTN, 16'h0000, 1'b0, OP_NORMAL, 16'h0000);
        check_eq("ertn redirect", 32'd1, 32'(redirect_valid_o));
        check_eq("ertn target", era_rd, redirect_pc_o);
        check_eq("ertn flush", 32'h7f, 32'(flush_o));
        clear_slots();
    endtask

    task automatic test_idle();
        logic [31:0] idle_pc;
        drive_slots(OP_IDLE, 16'h0000, 1'b0, OP_NORMAL, 16'h0000);
        idle_pc = pc0;
        check_eq("idle redirect", 32'd1, 32'(redirect_valid_o));
        check_eq("idle target", idle_pc, redirect_pc_o);
        clear_slots();
        // INE while idle moves ERA past the trapping pc
        drive_slots(OP_NORMAL, 16'h0080, 1'b0, OP_NORMAL, 16'h0000);
        check_eq("idle excp target", eentry_val, redirect_pc_o);
        clear_slots();
        read_check("idle era", `CSR_ERA, pc0 + 32'd4);
        read_check("idle estat", `CSR_ESTAT, estat_word(6'h0d, 9'd0));
    endtask

    task automatic test_backpressure();
        @(posedge clk);
        mem2_ready_i <= 2'b10;
        @(negedge clk);
        check_eq("mem2 stall advance", 32'b0000001, 32'(advance_o));
        check_eq("mem2 stall clear", 32'b0000010, 32'(clear_o));
        check_eq("mem2 stall flush", 32'd0, 32'(flush_o));
        @(posedge clk);
        mem2_ready_i <= 2'b11;
        mem1_ready_i <= 2'b01;
        @(negedge clk);
        check_eq("mem1 stall advance", 32'b0000011, 32'(advance_o));
        check_eq("mem1 stall clear", 32'b0000100, 32'(clear_o));
        @(posedge clk);
        mem1_ready_i <= 2'b11;
        ex_ready_i   <= 2'b10;
        @(negedge clk);
        check_eq("ex stall advance", 32'b0000111, 32'(advance_o));
        check_eq("ex stall clear", 32'b0001000, 32'(clear_o));
        @(posedge clk);
        ex_ready_i <= 2'b11;
        @(negedge clk);
        check_eq("no stall advance", 32'b1111111, 32'(advance_o));
        check_eq("no stall clear", 32'd0, 32'(clear_o));
    endtask

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        cycle_count      = 0;
        lcg_state        = 32'hb217;
        s0_valid_i       = 1'b0;
        s0_op_i          = OP_NORMAL;
        s0_pc_i          = '0;
        s0_excp_i        = '0;
        s0_mem_addr_i    = '0;
        s0_wb_we_i       = 1'b0;
        s0_wb_addr_i     = '0;
        s0_wb_data_i     = '0;
        s1_valid_i       = 1'b0;
        s1_op_i          = OP_NORMAL;
        s1_pc_i          = '0;
        s1_excp_i        = '0;
        s1_mem_addr_i    = '0;
        s1_wb_we_i       = 1'b0;
        s1_wb_addr_i     = '0;
        s1_wb_data_i     = '0;
        ex_ready_i       = 2'b11;
        mem1_ready_i     = 2'b11;
        mem2_ready_i     = 2'b11;
        s_axil_awaddr_i  = '0;
        s_axil_awvalid_i = 1'b0;
        s_axil_wdata_i   = '0;
        s_axil_wstrb_i   = '0;
        s_axil_wvalid_i  = 1'b0;
        s_axil_bready_i  = 1'b0;
        s_axil_araddr_i  = '0;
        s_axil_arvalid_i = 1'b0;
        s_axil_rready_i  = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_csr_access();
        test_dual_commit();
        test_excp_priority();
        test_tlbr_ertn();
        test_idle();
        test_backpressure();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* hw/commit_top.sv */
`timescale 1ns/1ns
`include "commit_settings.svh"

module commit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   s0_valid_i,
    input  commit_pkg::op_e        s0_op_i,
    input  logic [`ADDR_W-1:0]     s0_pc_i,
    input  logic [`EXCP_W-1:0]     s0_excp_i,
    input  logic [`ADDR_W-1:0]     s0_mem_addr_i,
    input  logic                   s0_wb_we_i,
    input  logic [`RF_AW-1:0]      s0_wb_addr_i,
    input  logic [`DATA_W-1:0]     s0_wb_data_i,
    input  logic                   s1_valid_i,
    input  commit_pkg::op_e        s1_op_i,
    input  logic [`ADDR_W-1:0]     s1_pc_i,
    input  logic [`EXCP_W-1:0]     s1_excp_i,
    input  logic [`ADDR_W-1:0]     s1_mem_addr_i,
    input  logic                   s1_wb_we_i,
    input  logic [`RF_AW-1:0]      s1_wb_addr_i,
    input  logic [`DATA_W-1:0]     s1_wb_data_i,
    input  logic [1:0]             ex_ready_i,
    input  logic [1:0]             mem1_ready_i,
    input  logic [1:0]             mem2_ready_i,
    output logic                   rf0_we_o,
    output logic [`RF_AW-1:0]      rf0_addr_o,
    output logic [`DATA_W-1:0]     rf0_data_o,
    output logic                   rf1_we_o,
    output logic [`RF_AW-1:0]      rf1_addr_o,
    output logic [`DATA_W-1:0]     rf1_data_o,
    output logic [1:0]             commit_mask_o,
    output logic                   redirect_valid_o,
    output logic [`ADDR_W-1:0]     redirect_pc_o,
    output logic [`STAGES-1:0]     flush_o,
    output logic [`STAGES-1:0]     advance_o,
    output logic [`STAGES-1:0]     clear_o,
    input  logic [`ADDR_W-1:0]     s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [`DATA_W-1:0]     s_axil_wdata_i,
    input  logic [`DATA_W/8-1:0]   s_axil_wstrb_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic [1:0]             s_axil_bresp_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [`ADDR_W-1:0]     s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [`DATA_W-1:0]     s_axil_rdata_o,
    output logic [1:0]             s_axil_rresp_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i
);
    import commit_pkg::*;

    // links between commit control and the CSR block
    logic [`ADDR_W-1:0] eentry;
    logic [`ADDR_W-1:0] tlbrentry;
    logic [`ADDR_W-1:0] era;
    logic               excp_take;
    ecode_e             excp_ecode;
    logic [`ESUB_W-1:0] excp_esubcode;
    logic [`ADDR_W-1:0] excp_era;
    logic               excp_badv_we;
    logic [`ADDR_W-1:0] excp_badv;
    logic               ertn_take;

    commit_ctrl u_ctrl (
        .*,
        .eentry_i        (eentry),
        .tlbrentry_i     (tlbrentry),
        .era_i           (era),
        .excp_take_o     (excp_take),
        .excp_ecode_o    (excp_ecode),
        .excp_esubcode_o (excp_esubcode),
        .excp_era_o      (excp_era),
        .excp_badv_we_o  (excp_badv_we),
        .excp_badv_o     (excp_badv),
        .ertn_take_o     (ertn_take)
    );

    excp_csr u_csr (
        .*,
        .excp_take_i     (excp_take),
        .excp_ecode_i    (excp_ecode),
        .excp_esubcode_i (excp_esubcode),
        .excp_era_i      (excp_era),
        .excp_badv_we_i  (excp_badv_we),
        .excp_badv_i     (excp_badv),
        .ertn_take_i     (ertn_take),
        .eentry_o        (eentry),
        .tlbrentry_o     (tlbrentry),
        .era_o           (era)
    );

endmodule

/* hw/excp_csr.sv */
`timescale 1ns/1ns
`include "commit_settings.svh"

module excp_csr (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   excp_take_i,
    input  commit_pkg::ecode_e     excp_ecode_i,
    input  logic [`ESUB_W-1:0]     excp_esubcode_i,
    input  logic [`ADDR_W-1:0]     excp_era_i,
    input  logic                   excp_badv_we_i,
    input  logic [`ADDR_W-1:0]     excp_badv_i,
    input  logic                   ertn_take_i,
    output logic [`ADDR_W-1:0]     eentry_o,
    output logic [`ADDR_W-1:0]     tlbrentry_o,
    output logic [`ADDR_W-1:0]     era_o,
    input  logic [`ADDR_W-1:0]     s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [`DATA_W-1:0]     s_axil_wdata_i,
    input  logic [`DATA_W/8-1:0]   s_axil_wstrb_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic [1:0]             s_axil_bresp_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [`ADDR_W-1:0]     s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [`DATA_W-1:0]     s_axil_rdata_o,
    output logic [1:0]             s_axil_rresp_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i
);
    import commit_pkg::*;

    logic [`ADDR_W-1:0]   eentry;
    logic [`ADDR_W-1:0]   tlbrentry;
    logic [`ADDR_W-1:0]   era;
    logic [`ADDR_W-1:0]   badv;
    ecode_e               estat_ecode;
    logic [`ESUB_W-1:0]   estat_esub;
    logic [`DATA_W-1:0]   estat;
    logic                 aw_got;
    logic                 w_got;
    logic [`ADDR_W-1:0]   aw_addr_q;
    logic [`DATA_W-1:0]   w_data_q;
    logic [`DATA_W/8-1:0] w_strb_q;
    logic                 aw_fire;
    logic                 w_fire;
    logic                 ar_fire;
    logic                 wr_go;
    logic [`ADDR_W-1:0]   wr_addr;
    logic [`DATA_W-1:0]   wr_data;
    logic [`DATA_W/8-1:0] wr_strb;

    function automatic logic [`DATA_W-1:0] merge_bytes(input logic [`DATA_W-1:0] old,
                                                       input logic [`DATA_W-1:0] data,
                                                       input logic [`DATA_W/8-1:0] strb);
        logic [`DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < `DATA_W / 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // address and data channels accepted independently
    assign s_axil_awready_o = ~aw_got & ~s_axil_bvalid_o;
    assign s_axil_wready_o  = ~w_got & ~s_axil_bvalid_o;
    assign aw_fire = s_axil_awvalid_i & s_axil_awready_o;
    assign w_fire  = s_axil_wvalid_i & s_axil_wready_o;
    assign wr_go   = (aw_got | aw_fire) & (w_got | w_fire);
    assign wr_addr = aw_got ? aw_addr_q : s_axil_awaddr_i;
    assign wr_data = w_got ? w_data_q : s_axil_wdata_i;
    assign wr_strb = w_got ? w_strb_q : s_axil_wstrb_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_got          <= 1'b0;
            w_got           <= 1'b0;
            s_axil_bvalid_o <= 1'b0;
        end else if (wr_go) begin
            aw_got          <= 1'b0;
            w_got           <= 1'b0;
            s_axil_bvalid_o <= 1'b1;
        end else begin
            if (aw_fire) begin
                aw_got <= 1'b1;
            end
            if (w_fire) begin
                w_got <= 1'b1;
            end
            if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_addr_q <= s_axil_awaddr_i;
        end
        if (w_fire) begin
            w_data_q <= s_axil_wdata_i;
            w_strb_q <= s_axil_wstrb_i;
        end
    end

    // hardware update comes last so it beats a software ERA write
    always_ff @(posedge clk) begin
        if (rst) begin
            eentry      <= '0;
            tlbrentry   <= '0;
            era         <= '0;
            badv        <= '0;
            estat_ecode <= EC_INT;
            estat_esub  <= '0;
        end else begin
            if (wr_go) begin
                case (wr_addr)
                    `CSR_EENTRY:    eentry <= merge_bytes(eentry, wr_data, wr_strb);
                    `CSR_TLBRENTRY: tlbrentry <= merge_bytes(tlbrentry, wr_data, wr_strb);
                    `CSR_ERA:       era <= merge_bytes(era, wr_data, wr_strb);
                    default:        ;
                endcase
            end
            if (excp_take_i) begin
                era         <= excp_era_i;
                estat_ecode <= excp_ecode_i;
                estat_esub  <= excp_esubcode_i;
                if (excp_badv_we_i) begin
                    badv <= excp_badv_i;
                end
            end else if (ertn_take_i) begin
                // handler done, drop the cause
                estat_ecode <= EC_INT;
                estat_esub  <= '0;
            end
        end
    end

    assign estat = (`DATA_W'(estat_esub) << `ESTAT_ESUB_LSB) |
                   (`DATA_W'(estat_ecode) << `ESTAT_ECODE_LSB);

    assign s_axil_arready_o = ~s_axil_rvalid_o;
    assign ar_fire = s_axil_arvalid_i & s_axil_arready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_axil_rvalid_o <= 1'b0;
        end else if (ar_fire) begin
            s_axil_rvalid_o <= 1'b1;
        end else if (s_axil_rready_i) begin
            s_axil_rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            case (s_axil_araddr_i)
                `CSR_EENTRY:    s_axil_rdata_o <= eentry;
                `CSR_TLBRENTRY: s_axil_rdata_o <= tlbrentry;
                `CSR_ERA:       s_axil_rdata_o <= era;
                `CSR_ESTAT:     s_axil_rdata_o <= estat;
                `CSR_BADV:      s_axil_rdata_o <= badv;
                default:        s_axil_rdata_o <= '0;
            endcase
        end
    end

    assign s_axil_bresp_o = 2'b00;
    assign s_axil_rresp_o = 2'b00;
    assign eentry_o       = eentry;
    assign tlbrentry_o    = tlbrentry;
    assign era_o          = era;

endmodule

/* hw/commit_ctrl.sv */
`timescale 1ns/1ns
`include "commit_settings.svh"

module commit_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        s0_valid_i,
    input  commit_pkg::op_e             s0_op_i,
    input  logic [`ADDR_W-1:0]          s0_pc_i,
    input  logic [`EXCP_W-1:0]          s0_excp_i,
    input  logic [`ADDR_W-1:0]          s0_mem_addr_i,
    input  logic                        s0_wb_we_i,
    input  logic [`RF_AW-1:0]           s0_wb_addr_i,
    input  logic [`DATA_W-1:0]          s0_wb_data_i,
    input  logic                        s1_valid_i,
    input  commit_pkg::op_e             s1_op_i,
    input  logic [`ADDR_W-1:0]          s1_pc_i,
    input  logic [`EXCP_W-1:0]          s1_excp_i,
    input  logic [`ADDR_W-1:0]          s1_mem_addr_i,
    input  logic                        s1_wb_we_i,
    input  logic [`RF_AW-1:0]           s1_wb_addr_i,
    input  logic [`DATA_W-1:0]          s1_wb_data_i,
    input  logic [1:0]                  ex_ready_i,
    input  logic [1:0]                  mem1_ready_i,
    input  logic [1:0]                  mem2_ready_i,
    input  logic [`ADDR_W-1:0]          eentry_i,
    input  logic [`ADDR_W-1:0]          tlbrentry_i,
    input  logic [`ADDR_W-1:0]          era_i,
    output logic                        rf0_we_o,
    output logic [`RF_AW-1:0]           rf0_addr_o,
    output logic [`DATA_W-1:0]          rf0_data_o,
    output logic                        rf1_we_o,
    output logic [`RF_AW-1:0]           rf1_addr_o,
    output logic [`DATA_W-1:0]          rf1_data_o,
    output logic [1:0]                  commit_mask_o,
    output logic                        redirect_valid_o,
    output logic [`ADDR_W-1:0]          redirect_pc_o,
    output logic [`STAGES-1:0]          flush_o,
    output logic [`STAGES-1:0]          advance_o,
    output logic [`STAGES-1:0]          clear_o,
    output logic                        excp_take_o,
    output commit_pkg::ecode_e          excp_ecode_o,
    output logic [`ESUB_W-1:0]          excp_esubcode_o,
    output logic [`ADDR_W-1:0]          excp_era_o,
    output logic                        excp_badv_we_o,
    output logic [`ADDR_W-1:0]          excp_badv_o,
    output logic                        ertn_take_o
);
    import commit_pkg::*;

    logic                s0_excp;
    logic                s1_excp;
    logic                any_excp;
    logic                s0_commit;
    logic                s1_commit;
    logic [`EXCP_W-1:0]  win_vec;
    logic [`ADDR_W-1:0]  win_pc;
    logic [`ADDR_W-1:0]  win_mem_addr;
    excp_bit_e           cause;
    logic                fetch_cause;
    logic                mem_cause;
    logic                tlbr_cause;
    logic                ertn_seen;
    logic                idle_commit;
    logic                in_idle;
    logic                adv_front;
    logic                adv_mem1;
    logic                adv_mem2;

    // an exception only counts on a valid slot
    assign s0_excp  = s0_valid_i & (|s0_excp_i);
    assign s1_excp  = s1_valid_i & (|s1_excp_i);
    assign any_excp = s0_excp | s1_excp;

    // slot 1 is squashed behind any special op in slot 0
    assign s0_commit     = s0_valid_i & ~s0_excp;
    assign s1_commit     = s1_valid_i & ~any_excp & (s0_op_i == OP_NORMAL);
    assign commit_mask_o = {s1_commit, s0_commit};

    assign rf0_we_o   = s0_commit & s0_wb_we_i;
    assign rf0_addr_o = s0_wb_addr_i;
    assign rf0_data_o = s0_wb_data_i;
    assign rf1_we_o   = s1_commit & s1_wb_we_i;
    assign rf1_addr_o = s1_wb_addr_i;
    assign rf1_data_o = s1_wb_data_i;

    // older slot wins
    assign win_vec      = s0_excp ? s0_excp_i : s1_excp_i;
    assign win_pc       = s0_excp ? s0_pc_i : s1_pc_i;
    assign win_mem_addr = s0_excp ? s0_mem_addr_i : s1_mem_addr_i;

    // lowest set bit, so scan downwards
    always_comb begin
        cause = EB_INT;
        for (int i = `EXCP_W - 1; i >= 0; i--) begin
            if (win_vec[i]) begin
                cause = excp_bit_e'(i);
            end
        end
    end

    always_comb begin
        case (cause)
            EB_INT:                excp_ecode_o = EC_INT;
            EB_ADEF, EB_ADEM:      excp_ecode_o = EC_ADE;
            EB_TLBR_F, EB_TLBR_M:  excp_ecode_o = EC_TLBR;
            EB_PIF:                excp_ecode_o = EC_PIF;
            EB_PPI_F, EB_PPI_M:    excp_ecode_o = EC_PPI;
            EB_SYS:                excp_ecode_o = EC_SYS;
            EB_BRK:                excp_ecode_o = EC_BRK;
            EB_INE:                excp_ecode_o = EC_INE;
            EB_IPE:                excp_ecode_o = EC_IPE;
            EB_ALE:                excp_ecode_o = EC_ALE;
            EB_PME:                excp_ecode_o = EC_PME;
            EB_PIS:                excp_ecode_o = EC_PIS;
            default:               excp_ecode_o = EC_PIL;
        endcase
    end

    // fetch causes report the pc, memory causes the data address
    assign fetch_cause = (cause >= EB_ADEF) && (cause <= EB_PPI_F);
    assign mem_cause   = (cause >= EB_ALE);
    assign tlbr_cause  = (cause == EB_TLBR_F) || (cause == EB_TLBR_M);

    assign excp_take_o     = any_excp;
    assign excp_esubcode_o = (cause == EB_ADEM) ? `ESUB_ADEM : '0;
    assign excp_era_o      = in_idle ? win_pc + `ADDR_W'd4 : win_pc;
    assign excp_badv_we_o  = any_excp & (fetch_cause | mem_cause);
    assign excp_badv_o     = fetch_cause ? win_pc : win_mem_addr;

    assign ertn_seen   = (s0_valid_i & (s0_op_i == OP_ERTN)) |
                         (s1_valid_i & (s1_op_i == OP_ERTN));
    assign ertn_take_o = ertn_seen & ~any_excp;
    assign idle_commit = s0_commit & (s0_op_i == OP_IDLE);

    // idle until something traps
    always_ff @(posedge clk) begin
        if (rst) begin
            in_idle <= 1'b0;
        end else if (any_excp) begin
            in_idle <= 1'b0;
        end else if (idle_commit) begin
            in_idle <= 1'b1;
        end
    end

    assign redirect_valid_o = any_excp | ertn_seen | idle_commit;

    always_comb begin
        if (any_excp && tlbr_cause) begin
            redirect_pc_o = tlbrentry_i;
        end else if (any_excp) begin
            redirect_pc_o = eentry_i;
        end else if (ertn_seen) begin
            redirect_pc_o = era_i;
        end else if (idle_commit) begin
            redirect_pc_o = s0_pc_i;
        end else begin
            redirect_pc_o = '0;
        end
    end

    // stage bits {frontend, id, dispatch, ex, mem1, mem2, wb}
    assign adv_mem2  = &mem2_ready_i;
    assign adv_mem1  = adv_mem2 & (&mem1_ready_i);
    assign adv_front = adv_mem1 & (&ex_ready_i);

    assign advance_o = {{(`STAGES - 3){adv_front}}, adv_mem1, adv_mem2, 1'b1};
    assign flush_o   = {`STAGES{redirect_valid_o}};
    // bubble where the later stage moves on and this one holds
    assign clear_o   = {advance_o[`STAGES-2:0] & ~advance_o[`STAGES-1:1], 1'b0};

endmodule

/* hw/commit_pkg.sv */
package commit_pkg;

    // class of the instruction leaving write-back
    typedef enum logic [2:0] {
        OP_NORMAL  = 3'd0,
        OP_ERTN    = 3'd1,
        OP_SYSCALL = 3'd2,
        OP_BREAK   = 3'd3,
        OP_IDLE    = 3'd4
    } op_e;

    // bit positions in the exception vector, lowest bit wins
    typedef enum logic [3:0] {
        EB_INT    = 4'd0,
        EB_ADEF   = 4'd1,
        EB_TLBR_F = 4'd2,
        EB_PIF    = 4'd3,
        EB_PPI_F  = 4'd4,
        EB_SYS    = 4'd5,
        EB_BRK    = 4'd6,
        EB_INE    = 4'd7,
        EB_IPE    = 4'd8,
        EB_ALE    = 4'd9,
        EB_ADEM   = 4'd10,
        EB_TLBR_M = 4'd11,
        EB_PME    = 4'd12,
        EB_PPI_M  = 4'd13,
        EB_PIS    = 4'd14,
        EB_PIL    = 4'd15
    } excp_bit_e;

    // architectural ecode values as seen in ESTAT
    typedef enum logic [5:0] {
        EC_INT  = 6'h00,
        EC_PIL  = 6'h01,
        EC_PIS  = 6'h02,
        EC_PIF  = 6'h03,
        EC_PME  = 6'h04,
        EC_PPI  = 6'h07,
        EC_ADE  = 6'h08,
        EC_ALE  = 6'h09,
        EC_SYS  = 6'h0B,
        EC_BRK  = 6'h0C,
        EC_INE  = 6'h0D,
        EC_IPE  = 6'h0E,
        EC_TLBR = 6'h3F
    } ecode_e;

endpackage

/* hw/commit_settings.svh */
`ifndef COMMIT_SETTINGS_SVH
`define COMMIT_SETTINGS_SVH

`define ADDR_W 32
`define DATA_W 32
`define RF_AW 5
`define EXCP_W 16
`define STAGES 7
`define ESUB_W 9

// csr offsets on the AXI4-Lite port
`define CSR_EENTRY 32'h00
`define CSR_TLBRENTRY 32'h04
`define CSR_ERA 32'h08
`define CSR_ESTAT 32'h0C
`define CSR_BADV 32'h10

`define ESUB_ADEM 9'd1
// ESTAT fields: ecode at 21:16, esubcode at 30:22
`define ESTAT_ECODE_LSB 16
`define ESTAT_ESUB_LSB 22

`endif
